// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - fetch_pkg.sv
  - pipe_reg.sv
  - fetch_unit.sv
  - decode_stage.sv
  - execute_stage.sv
  - fetch_top.sv
  - target: simulation
    files:
      - tb_inst_mem.sv
      - tb_fetch_top.sv

// ==== decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage import fetch_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        redirect,

    // From fetch
    input  logic        f_valid,
    output logic        f_ready,
    input  logic [31:0] f_pc,
    input  logic [31:0] f_inst,
    input  logic        f_epoch,

    // To execute
    output logic        d_valid,
    input  logic        d_ready,
    output logic [31:0] d_pc,
    output logic [31:0] d_inst,
    output inst_class_t d_class,
    output logic [31:0] d_target,
    output logic        d_epoch
);

    logic        is_jal;
    logic [31:0] imm_j;
    decoded_t    dec_in;
    decoded_t    dec_out;

    // --------------------------------------------------
    // Classify and compute target
    // --------------------------------------------------

    assign is_jal = f_inst[6:0] == OPCODE_JAL;

    // J-type immediate, bit 0 always zero
    assign imm_j = {{11{f_inst[31]}}, f_inst[31], f_inst[19:12],
                    f_inst[20], f_inst[30:21], 1'b0};

    always_comb begin
        dec_in.pc         = f_pc;
        dec_in.inst       = f_inst;
        dec_in.inst_class = is_jal ? JAL : SEQ;
        // Fall-through address for everything but JAL
        dec_in.target     = is_jal ? f_pc + imm_j : f_pc + 32'd4;
        dec_in.epoch      = f_epoch;
    end

    // Wrong-path content is dropped on redirect
    pipe_reg #(
        .payload_t (decoded_t)
    ) u_dec_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (redirect),
        .in_valid  (f_valid),
        .in_ready  (f_ready),
        .in_data   (dec_in),
        .out_valid (d_valid),
        .out_ready (d_ready),
        .out_data  (dec_out)
    );

    assign d_pc     = dec_out.pc;
    assign d_inst   = dec_out.inst;
    assign d_class  = dec_out.inst_class;
    assign d_target = dec_out.target;
    assign d_epoch  = dec_out.epoch;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage import fetch_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // From decode
    input  logic        d_valid,
    output logic        d_ready,
    input  logic [31:0] d_pc,
    input  logic [31:0] d_inst,
    input  inst_class_t d_class,
    input  logic [31:0] d_target,
    input  logic        d_epoch,

    // Redirect back to fetch and decode
    output logic        redirect,
    output logic [31:0] redirect_pc,

    // Retire stream
    output logic        retire_valid,
    input  logic        retire_ready,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output inst_class_t retire_class
);

    logic    epoch;
    logic    stale;
    logic    ret_in_ready;
    retire_t ret_in;
    retire_t ret_out;

    // Old-path items are swallowed right away
    assign stale   = d_epoch != epoch;
    assign d_ready = stale || ret_in_ready;

    assign redirect    = d_valid && !stale && ret_in_ready && d_class == JAL;
    assign redirect_pc = d_target;

    always_ff @(posedge clock) begin
        if (reset) begin
            epoch <= 1'b0;
        end else if (redirect) begin
            epoch <= !epoch;
        end
    end

    assign ret_in.pc         = d_pc;
    assign ret_in.inst       = d_inst;
    assign ret_in.inst_class = d_class;

    pipe_reg #(
        .payload_t (retire_t)
    ) u_ret_reg (
        .clock     (clock),
        .reset     (reset),
        .flush     (1'b0),
        .in_valid  (d_valid && !stale),
        .in_ready  (ret_in_ready),
        .in_data   (ret_in),
        .out_valid (retire_valid),
        .out_ready (retire_ready),
        .out_data  (ret_out)
    );

    assign retire_pc    = ret_out.pc;
    assign retire_inst  = ret_out.inst;
    assign retire_class = ret_out.inst_class;

    // Decode is flushed, so no JAL can follow right behind
    a_redirect_pulse: assert property (
        @(posedge clock) disable iff (reset)
        redirect |=> !redirect
    ) else $error("execute_stage: redirect held for two cycles");

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // --------------------------------------------------
    // Instruction classes
    // --------------------------------------------------

    // JAL jumps to its target, everything else falls through to pc+4
    typedef enum logic {
        SEQ = 1'b0,
        JAL = 1'b1
    } inst_class_t;

    localparam logic [6:0] OPCODE_JAL = 7'b1101111;

    // --------------------------------------------------
    // Stage payloads
    // --------------------------------------------------

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        inst_class_t inst_class;
        logic [31:0] target;
        logic        epoch;
    } decoded_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        inst_class_t inst_class;
    } retire_t;

    // --------------------------------------------------
    // AXI4 field encodings
    // --------------------------------------------------

    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

endpackage

// ==== fetch_top.sv ====
`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h3000_0000,
    parameter logic [3:0]  AXI_ID   = 4'd0
) (
    input  logic        clock,
    input  logic        reset,

    // AXI4 read channel
    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid,

    // Retire stream
    output logic        retire_valid,
    input  logic        retire_ready,
    output logic [31:0] retire_pc,
    output logic [31:0] retire_inst,
    output inst_class_t retire_class
);

    // --------------------------------------------------
    // Stage links
    // --------------------------------------------------

    logic        f_valid;
    logic        f_ready;
    logic [31:0] f_pc;
    logic [31:0] f_inst;
    logic        f_epoch;

    logic        d_valid;
    logic        d_ready;
    logic [31:0] d_pc;
    logic [31:0] d_inst;
    inst_class_t d_class;
    logic [31:0] d_target;
    logic        d_epoch;

    logic        redirect;
    logic [31:0] redirect_pc;

    fetch_unit #(
        .RESET_PC (RESET_PC),
        .AXI_ID   (AXI_ID)
    ) u_fetch (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .f_valid     (f_valid),
        .f_ready     (f_ready),
        .f_pc        (f_pc),
        .f_inst      (f_inst),
        .f_epoch     (f_epoch),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .arid        (arid),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rid         (rid)
    );

    decode_stage u_decode (
        .clock    (clock),
        .reset    (reset),
        .redirect (redirect),
        .f_valid  (f_valid),
        .f_ready  (f_ready),
        .f_pc     (f_pc),
        .f_inst   (f_inst),
        .f_epoch  (f_epoch),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .d_pc     (d_pc),
        .d_inst   (d_inst),
        .d_class  (d_class),
        .d_target (d_target),
        .d_epoch  (d_epoch)
    );

    execute_stage u_execute (
        .clock        (clock),
        .reset        (reset),
        .d_valid      (d_valid),
        .d_ready      (d_ready),
        .d_pc         (d_pc),
        .d_inst       (d_inst),
        .d_class      (d_class),
        .d_target     (d_target),
        .d_epoch      (d_epoch),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_class (retire_class)
    );

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit import fetch_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h3000_0000,
    parameter logic [3:0]  AXI_ID   = 4'd0
) (
    input  logic        clock,
    input  logic        reset,

    // Redirect from execute
    input  logic        redirect,
    input  logic [31:0] redirect_pc,

    // Fetched word to decode
    output logic        f_valid,
    input  logic        f_ready,
    output logic [31:0] f_pc,
    output logic [31:0] f_inst,
    output logic        f_epoch,

    // AXI4 read address channel
    output logic        arvalid,
    input  logic        arready,
    output logic [31:0] araddr,
    output logic [3:0]  arid,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,

    // AXI4 read data channel
    input  logic        rvalid,
    output logic        rready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rlast,
    input  logic [3:0]  rid
);

    logic [31:0] pc;
    logic [31:0] pc_next;
    logic        epoch;
    logic        outstanding;
    logic        discard;
    logic        ar_fire;
    logic        r_fire;
    logic        f_fire;
    logic        idle;
    logic        launch;

    // Single beat word reads
    assign arid    = AXI_ID;
    assign arlen   = 8'd0;
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_INCR;
    assign rready  = 1'b1;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;
    assign f_fire  = f_valid && f_ready;

    // Only true in the first cycle after reset
    assign idle = !arvalid && !outstanding && !f_valid;

    // Start a new read when the single token comes back
    assign launch = idle
                 || (f_valid && (f_fire || redirect))
                 || (r_fire && (discard || redirect));

    // Redirect wins over sequential advance
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (f_fire) begin
            pc_next = pc + 32'd4;
        end else begin
            pc_next = pc;
        end
    end

    // --------------------------------------------------
    // PC and epoch
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            pc    <= RESET_PC;
            epoch <= 1'b0;
        end else begin
            pc <= pc_next;
            if (redirect) begin
                epoch <= !epoch;
            end
        end
    end

    // --------------------------------------------------
    // Read request tracking
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid     <= 1'b0;
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end else begin
            if (ar_fire) begin
                arvalid <= 1'b0;
            end else if (launch) begin
                arvalid <= 1'b1;
            end

            if (ar_fire) begin
                outstanding <= 1'b1;
            end else if (r_fire) begin
                outstanding <= 1'b0;
            end

            // Read already issued for the old path
            if (r_fire) begin
                discard <= 1'b0;
            end else if (redirect && (arvalid || outstanding)) begin
                discard <= 1'b1;
            end
        end
    end

    // Address is held until the AR handshake
    always_ff @(posedge clock) begin
        if (launch) begin
            araddr <= pc_next;
        end
    end

    // --------------------------------------------------
    // Output word
    // --------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            f_valid <= 1'b0;
        end else if (r_fire && !discard && !redirect) begin
            f_valid <= 1'b1;
        end else if (f_fire || redirect) begin
            f_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (r_fire) begin
            f_pc    <= araddr;
            f_inst  <= rdata;
            f_epoch <= epoch;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    a_r_expected: assert property (
        @(posedge clock) disable iff (reset)
        rvalid |-> outstanding && rlast && rid == AXI_ID
    ) else $error("fetch_unit: unexpected R beat");

    a_r_okay: assert property (
        @(posedge clock) disable iff (reset)
        rvalid |-> rresp == AXI_RESP_OKAY
    ) else $error("fetch_unit: read response not OKAY");

    a_ar_aligned: assert property (
        @(posedge clock) disable iff (reset)
        arvalid |-> araddr[1:0] == 2'b00
    ) else $error("fetch_unit: misaligned araddr");

endmodule

// ==== pipe_reg.sv ====
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     flush,

    // Upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;

    // Slot is free, or its entry leaves in this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= in_data;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Stalled entry stays put until taken or flushed
    a_hold_stable: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_data)
    ) else $error("pipe_reg: output changed while stalled");

endmodule

// ==== tb.f ====
fetch_pkg.sv
pipe_reg.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
fetch_top.sv
tb_inst_mem.sv
tb_fetch_top.sv

// ==== tb_fetch_top.sv ====
`timescale 1ns/100ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam logic [31:0] RESET_PC       = 32'h3000_0000;
    localparam logic [3:0]  AXI_ID         = 4'd0;
    localparam int          NUM_RETIRE     = 2000;
    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + NUM_RETIRE * 20;

    logic        clock;
    logic        reset;

    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic [3:0]  arid;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic [3:0]  rid;

    logic        retire_valid;
    logic        retire_ready;
    logic [31:0] retire_pc;
    logic [31:0] retire_inst;
    inst_class_t retire_class;

    // Program image with its own classification
    logic [31:0] program_words [0:1023];
    logic        word_is_jal   [0:1023];
    logic [31:0] pc_step       [0:1023];

    int          mismatch_errors = 0;
    int          other_errors    = 0;
    int          retired         = 0;
    logic [31:0] expected_pc;
    logic        last_was_jal;

    // Retire output seen stalled at the last falling edge
    logic        stalled;
    logic [31:0] held_pc;
    logic [31:0] held_inst;
    inst_class_t held_class;

    initial clock = 1'b0;
    always #50 clock = !clock;

    fetch_top #(
        .RESET_PC (RESET_PC),
        .AXI_ID   (AXI_ID)
    ) DUT (
        .clock        (clock),
        .reset        (reset),
        .arvalid      (arvalid),
        .arready      (arready),
        .araddr       (araddr),
        .arid         (arid),
        .arlen        (arlen),
        .arsize       (arsize),
        .arburst      (arburst),
        .rvalid       (rvalid),
        .rready       (rready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rlast        (rlast),
        .rid          (rid),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_pc    (retire_pc),
        .retire_inst  (retire_inst),
        .retire_class (retire_class)
    );

    tb_inst_mem #(
        .AXI_ID (AXI_ID)
    ) u_mem (
        .clock   (clock),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arid    (arid),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rid     (rid)
    );

    // --------------------------------------------------
    // Program generation
    // --------------------------------------------------

    task automatic build_program();
        logic [31:0] word;
        logic [20:0] imm;
        logic [4:0]  rd;
        int          offset_words;
        for (int i = 0; i < 1024; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                // Nonzero jump of up to 16 words either way
                offset_words = int'($urandom_range(31, 0)) - 16;
                if (offset_words >= 0) begin
                    offset_words++;
                end
                imm  = 21'(offset_words * 4);
                rd   = 5'($urandom_range(31, 0));
                word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
                word_is_jal[i] = 1'b1;
                pc_step[i]     = 32'(offset_words * 4);
            end else begin
                word = $urandom();
                while (word[6:0] == OPCODE_JAL) begin
                    word = $urandom();
                end
                word_is_jal[i] = 1'b0;
                pc_step[i]     = 32'd4;
            end
            program_words[i] = word;
            u_mem.mem[i]     = word;
        end
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    task automatic check_retire();
        int          idx;
        logic [31:0] exp_inst;
        inst_class_t exp_class;
        idx       = int'(expected_pc[11:2]);
        exp_inst  = program_words[idx];
        exp_class = word_is_jal[idx] ? JAL : SEQ;
        if (retired == 0) begin
            assert (retire_pc == RESET_PC) else begin
                $display("%0t: first retirement is not at the reset address", $time);
                other_errors++;
            end
        end
        assert (retire_pc == expected_pc) else begin
            $display("Mismatch at %0t: retire_pc expected %h got %h",
                     $time, expected_pc, retire_pc);
            mismatch_errors++;
            if (last_was_jal) begin
                $display("%0t: wrong-path word at %h retired after a JAL", $time, retire_pc);
                other_errors++;
            end
        end
        assert (retire_inst == exp_inst) else begin
            $display("Mismatch at %0t: retire_inst expected %h got %h",
                     $time, exp_inst, retire_inst);
            mismatch_errors++;
        end
        assert (retire_class == exp_class) else begin
            $display("Mismatch at %0t: retire_class expected %0d got %0d",
                     $time, exp_class, retire_class);
            mismatch_errors++;
        end
        last_was_jal = word_is_jal[idx];
        expected_pc  = expected_pc + pc_step[idx];
        retired++;
    endtask

    // Stalled output must not move
    task automatic check_hold();
        if (stalled) begin
            assert (retire_valid) else begin
                $display("%0t: retire_valid dropped before the handshake", $time);
                other_errors++;
            end
            assert (retire_pc == held_pc) else begin
                $display("Mismatch at %0t: retire_pc expected %h got %h while stalled",
                         $time, held_pc, retire_pc);
                mismatch_errors++;
            end
            assert (retire_inst == held_inst) else begin
                $display("Mismatch at %0t: retire_inst expected %h got %h while stalled",
                         $time, held_inst, retire_inst);
                mismatch_errors++;
            end
            assert (retire_class == held_class) else begin
                $display("Mismatch at %0t: retire_class expected %0d got %0d while stalled",
                         $time, held_class, retire_class);
                mismatch_errors++;
            end
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d mismatch, %0d protocol, %0d other, %0d retired",
                 mismatch_errors, u_mem.protocol_errors, other_errors, retired);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        int seed;
        seed = 32'heffbe2ed;
        void'($urandom(seed));
        reset        = 1'b1;
        retire_ready = 1'b0;
        expected_pc  = RESET_PC;
        last_was_jal = 1'b0;
        stalled      = 1'b0;
        build_program();
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        while (retired < NUM_RETIRE) begin
            @(negedge clock);
            check_hold();
            retire_ready = $urandom_range(9, 0) < 7;
            if (retire_valid && retire_ready) begin
                check_retire();
            end
            stalled    = retire_valid && !retire_ready;
            held_pc    = retire_pc;
            held_inst  = retire_inst;
            held_class = retire_class;
        end
        print_counts();
        if (mismatch_errors + other_errors + u_mem.protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("Timeout with %0d of %0d retirements seen", retired, NUM_RETIRE);
        other_errors++;
        print_counts();
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb_inst_mem.sv ====
`timescale 1ns/100ps

module tb_inst_mem import fetch_pkg::*; #(
    parameter logic [3:0] AXI_ID = 4'd0
) (
    input  logic        clock,
    input  logic        reset,

    // AXI4 read address channel
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    input  logic [3:0]  arid,
    input  logic [7:0]  arlen,
    input  logic [2:0]  arsize,
    input  logic [1:0]  arburst,

    // AXI4 read data channel
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid
);

    // 4 KB image that wraps on address bits 11:2
    logic [31:0] mem [0:1023];
    int          protocol_errors = 0;

    logic [31:0] req_addr;
    logic [3:0]  req_id;

    task automatic compare_field(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Mismatch at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            protocol_errors++;
        end
    endtask

    task automatic check_no_ar();
        assert (!arvalid) else begin
            $display("%0t: new read request while a read is still outstanding", $time);
            protocol_errors++;
        end
    endtask

    // --------------------------------------------------
    // Request and response sequencing
    // --------------------------------------------------

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = AXI_RESP_OKAY;
        rlast   = 1'b0;
        rid     = '0;
        forever begin
            if (reset !== 1'b0 || arvalid !== 1'b1) begin
                @(negedge clock);
            end else begin
                repeat ($urandom_range(3, 0)) @(negedge clock);
                compare_field("araddr[1:0]", 0, int'(araddr[1:0]));
                compare_field("arid", int'(AXI_ID), int'(arid));
                compare_field("arlen", 0, int'(arlen));
                compare_field("arsize", int'(AXI_SIZE_WORD), int'(arsize));
                compare_field("arburst", int'(AXI_BURST_INCR), int'(arburst));
                req_addr = araddr;
                req_id   = arid;
                arready  = 1'b1;
                @(negedge clock);
                arready = 1'b0;
                check_no_ar();
                repeat ($urandom_range(4, 0)) begin
                    @(negedge clock);
                    check_no_ar();
                end
                compare_field("rready", 1, int'(rready));
                rvalid = 1'b1;
                rdata  = mem[req_addr[11:2]];
                rresp  = AXI_RESP_OKAY;
                rid    = req_id;
                rlast  = 1'b1;
                @(negedge clock);
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

endmodule
